//--- rtl/alu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu (
    input  pipe_pkg::id_ex_t   id_ex,
    input  isa_pkg::fwd_sel_e  src1_sel,
    input  isa_pkg::fwd_sel_e  src2_sel,
    input  logic [`DATA_W-1:0] ex_mem_result,
    input  logic [`DATA_W-1:0] mem_wb_data,
    input  logic               carry_in,
    output logic [`DATA_W-1:0] op1,
    output logic [`DATA_W-1:0] op2,
    output logic [`DATA_W-1:0] result,
    output isa_pkg::flags_t    alu_flags
);

    logic [`DATA_W-1:0] src2_fwd;

    // Operand muxes
    always_comb begin
        case (src1_sel)
            isa_pkg::FWD_EX_MEM: op1 = ex_mem_result;
            isa_pkg::FWD_MEM_WB: op1 = mem_wb_data;
            default:             op1 = id_ex.rdest_data;
        endcase

        case (src2_sel)
            isa_pkg::FWD_EX_MEM: src2_fwd = ex_mem_result;
            isa_pkg::FWD_MEM_WB: src2_fwd = mem_wb_data;
            default:             src2_fwd = id_ex.rsrc_data;
        endcase

        op2 = id_ex.imm_sel ? id_ex.imm : src2_fwd;
    end

    always_comb begin
        logic [`DATA_W:0] wide;
        logic             carry;

        wide  = '0;
        carry = carry_in;
        case (id_ex.alu_op)
            isa_pkg::ALU_MOV: wide[`DATA_W-1:0] = op2;
            isa_pkg::ALU_ADD: begin
                wide  = {1'b0, op1} + {1'b0, op2};
                carry = wide[`DATA_W];
            end
            isa_pkg::ALU_SUB: begin
                wide  = {1'b0, op1} - {1'b0, op2}; // Top bit is the borrow
                carry = wide[`DATA_W];
            end
            isa_pkg::ALU_AND: wide[`DATA_W-1:0] = op1 & op2;
            isa_pkg::ALU_OR:  wide[`DATA_W-1:0] = op1 | op2;
            isa_pkg::ALU_NOT: wide[`DATA_W-1:0] = ~op1;
            isa_pkg::ALU_INC: begin
                wide  = {1'b0, op1} + 1'b1;
                carry = wide[`DATA_W];
            end
            isa_pkg::ALU_DEC: begin
                wide  = {1'b0, op1} - 1'b1;
                carry = wide[`DATA_W];
            end
            isa_pkg::ALU_SHL: begin
                wide = {1'b0, op1} << id_ex.shamt;
                if (id_ex.shamt != '0) begin
                    carry = wide[`DATA_W]; // Last bit out of the top
                end
            end
            isa_pkg::ALU_SHR: begin
                {wide[`DATA_W-1:0], carry} = {op1, 1'b0} >> id_ex.shamt;
                if (id_ex.shamt == '0) begin
                    carry = carry_in;
                end
            end
            isa_pkg::ALU_SETC: begin
                wide[`DATA_W-1:0] = op1;
                carry = 1'b1;
            end
            isa_pkg::ALU_CLRC: begin
                wide[`DATA_W-1:0] = op1;
                carry = 1'b0;
            end
            default: wide[`DATA_W-1:0] = op1; // NOP passes op1
        endcase

        result      = wide[`DATA_W-1:0];
        alu_flags.c = carry;
        alu_flags.n = result[`DATA_W-1];
        alu_flags.z = (result == '0);
    end

endmodule

//--- rtl/branch_controller.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module branch_controller (
    input  isa_pkg::jump_e     jump,
    input  isa_pkg::flags_t    flags,
    input  logic [`DATA_W-1:0] target,
    input  logic [`PC_W-1:0]   pc,
    output logic               branch_taken,
    output logic [`PC_W-1:0]   new_pc
);

    always_comb begin
        case (jump)
            isa_pkg::JMP_Z:      branch_taken = flags.z;
            isa_pkg::JMP_N:      branch_taken = flags.n;
            isa_pkg::JMP_C:      branch_taken = flags.c;
            isa_pkg::JMP_ALWAYS: branch_taken = 1'b1;
            default:             branch_taken = 1'b0;
        endcase
    end

    // Target is a signed register value
    assign new_pc = branch_taken
        ? {{(`PC_W-`DATA_W){target[`DATA_W-1]}}, target}
        : pc;

endmodule

//--- rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths shared by the execute stage

// Operand and result width
`define DATA_W 16

// Program counter width
`define PC_W 32

// Register file index width, eight registers
`define RADDR_W 3

// Shift amount covers 0 to DATA_W-1
`define SHAMT_W 4

`endif

//--- rtl/execute_stage.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::mem_wb_t  mem_wb,
    input  isa_pkg::flags_t    popped_flags,
    output pipe_pkg::ex_mem_t  ex_mem,
    output isa_pkg::flags_t    flags,
    output logic               branch_taken,
    output logic [`PC_W-1:0]   new_pc
);

    isa_pkg::fwd_sel_e  src1_sel;
    isa_pkg::fwd_sel_e  src2_sel;
    logic [`DATA_W-1:0] op1;
    logic [`DATA_W-1:0] op2;
    logic [`DATA_W-1:0] result;
    isa_pkg::flags_t    alu_flags;
    pipe_pkg::ex_mem_t  ex_mem_d;

    forwarding_unit u_fwd (
        .rdest    (id_ex.rdest),
        .rsrc     (id_ex.rsrc),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .src1_sel (src1_sel),
        .src2_sel (src2_sel)
    );

    alu u_alu (
        .id_ex         (id_ex),
        .src1_sel      (src1_sel),
        .src2_sel      (src2_sel),
        .ex_mem_result (ex_mem.result),
        .mem_wb_data   (mem_wb.data),
        .carry_in      (flags.c),
        .op1           (op1),
        .op2           (op2),
        .result        (result),
        .alu_flags     (alu_flags)
    );

    flag_register u_flags (
        .clk          (clk),
        .rst_n        (rst_n),
        .flag_en      (id_ex.flag_en),
        .flag_restore (id_ex.flag_restore),
        .alu_flags    (alu_flags),
        .popped_flags (popped_flags),
        .flags        (flags)
    );

    // Jump target is the forwarded destination register
    branch_controller u_branch (
        .jump         (id_ex.jump),
        .flags        (flags),
        .target       (op1),
        .pc           (id_ex.pc),
        .branch_taken (branch_taken),
        .new_pc       (new_pc)
    );

    always_comb begin
        ex_mem_d.result      = result;
        ex_mem_d.store_data  = op2;
        ex_mem_d.rdest       = id_ex.rdest;
        ex_mem_d.reg_write   = id_ex.reg_write;
        ex_mem_d.wb_sel      = id_ex.wb_sel;
        ex_mem_d.mem_read    = id_ex.mem_read;
        ex_mem_d.mem_write   = id_ex.mem_write;
        ex_mem_d.mem_push    = id_ex.mem_push;
        ex_mem_d.mem_pop     = id_ex.mem_pop;
        ex_mem_d.outport_en  = id_ex.outport_en;
        ex_mem_d.pc          = id_ex.pc;
        ex_mem_d.pc_plus_one = id_ex.pc_plus_one;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

    // Memory stage takes one access per instruction
    property p_single_mem_access;
        @(posedge clk) disable iff (!rst_n)
        !(ex_mem.mem_read && ex_mem.mem_write);
    endproperty

    a_single_mem_access: assert property (p_single_mem_access)
        else $error("mem_read and mem_write both set in EX/MEM");

endmodule

//--- rtl/flag_register.sv
`timescale 1ns/1ns

module flag_register (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flag_en,
    input  logic            flag_restore,
    input  isa_pkg::flags_t alu_flags,
    input  isa_pkg::flags_t popped_flags,
    output isa_pkg::flags_t flags
);

    // Restore from the stack beats an ALU update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_restore) begin
            flags <= popped_flags;
        end else if (flag_en) begin
            flags <= alu_flags;
        end
    end

    // Flags hold across a cycle with no update request
    property p_flags_hold;
        @(posedge clk) disable iff (!rst_n)
        (!flag_en && !flag_restore) |=> $stable(flags);
    endproperty

    a_flags_hold: assert property (p_flags_hold)
        else $error("flags changed without flag_en or flag_restore");

endmodule

//--- rtl/forwarding_unit.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module forwarding_unit (
    input  logic [`RADDR_W-1:0] rdest,
    input  logic [`RADDR_W-1:0] rsrc,
    input  pipe_pkg::ex_mem_t   ex_mem,
    input  pipe_pkg::mem_wb_t   mem_wb,
    output isa_pkg::fwd_sel_e   src1_sel,
    output isa_pkg::fwd_sel_e   src2_sel
);

    // Younger instruction in EX/MEM wins over the one in MEM/WB
    function automatic isa_pkg::fwd_sel_e pick_src(
        input logic [`RADDR_W-1:0] idx,
        input pipe_pkg::ex_mem_t   em,
        input pipe_pkg::mem_wb_t   mw
    );
        isa_pkg::fwd_sel_e sel;
        if (em.reg_write && em.rdest == idx) begin
            sel = isa_pkg::FWD_EX_MEM;
        end else if (mw.reg_write && mw.rdest == idx) begin
            sel = isa_pkg::FWD_MEM_WB;
        end else begin
            sel = isa_pkg::FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        src1_sel = pick_src(rdest, ex_mem, mem_wb); // Destination operand
        src2_sel = pick_src(rsrc, ex_mem, mem_wb);  // Source operand
    end

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

    // ALU operations decoded from the opcode field
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_MOV  = 4'd1,
        ALU_ADD  = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOT  = 4'd6,
        ALU_INC  = 4'd7,
        ALU_DEC  = 4'd8,
        ALU_SHL  = 4'd9,
        ALU_SHR  = 4'd10,
        ALU_SETC = 4'd11,
        ALU_CLRC = 4'd12
    } alu_op_e;

    // Jump conditions
    typedef enum logic [2:0] {
        JMP_NONE   = 3'd0,
        JMP_Z      = 3'd1,
        JMP_N      = 3'd2,
        JMP_C      = 3'd3,
        JMP_ALWAYS = 3'd4
    } jump_e;

    // Operand source, 2'b11 unused
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic c; // Carry
        logic n; // Negative
        logic z; // Zero
    } flags_t;

endpackage

//--- rtl/pipe_pkg.sv
`include "cpu_consts.svh"

package pipe_pkg;

    // Decoded instruction held in the ID/EX register
    typedef struct packed {
        isa_pkg::alu_op_e     alu_op;
        isa_pkg::jump_e       jump;
        logic [`DATA_W-1:0]   rdest_data;
        logic [`DATA_W-1:0]   rsrc_data;
        logic [`RADDR_W-1:0]  rdest;
        logic [`RADDR_W-1:0]  rsrc;
        logic [`DATA_W-1:0]   imm;
        logic                 imm_sel;    // Immediate replaces op2
        logic [`SHAMT_W-1:0]  shamt;
        logic                 flag_en;
        logic                 flag_restore;
        logic                 reg_write;
        logic [1:0]           wb_sel;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_push;
        logic                 mem_pop;
        logic                 outport_en;
        logic [`PC_W-1:0]     pc;
        logic [`PC_W-1:0]     pc_plus_one;
    } id_ex_t;

    // Write-back value fed back for forwarding
    typedef struct packed {
        logic                 reg_write;
        logic [`RADDR_W-1:0]  rdest;
        logic [`DATA_W-1:0]   data;
    } mem_wb_t;

    typedef struct packed {
        logic [`DATA_W-1:0]   result;
        logic [`DATA_W-1:0]   store_data;
        logic [`RADDR_W-1:0]  rdest;
        logic                 reg_write;
        logic [1:0]           wb_sel;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_push;
        logic                 mem_pop;
        logic                 outport_en;
        logic [`PC_W-1:0]     pc;
        logic [`PC_W-1:0]     pc_plus_one;
    } ex_mem_t;

endpackage

//--- verif/tb_execute_stage.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module tb_execute_stage;

    localparam int NUM_ROWS       = 27;
    localparam int TIMEOUT_CYCLES = NUM_ROWS + 20;

    localparam logic [1:0] SRC_REG = 2'd0;
    localparam logic [1:0] SRC_EXM = 2'd1;
    localparam logic [1:0] SRC_WB  = 2'd2;

    typedef struct packed {
        isa_pkg::alu_op_e op;
        isa_pkg::jump_e   jump;
        logic [2:0]       rdest;
        logic [2:0]       rsrc;
        logic [2:0]       ctl;     // imm_sel, flag_en, flag_restore
        logic [3:0]       wb;      // mem_wb reg_write and rdest
        logic [5:0]       pass;    // reg_write, read, write, push, pop, outport_en
        logic [3:0]       exp_src; // Expected source of op1 and op2
    } row_t;

    logic               clk;
    logic               rst_n;
    pipe_pkg::id_ex_t   id_ex;
    pipe_pkg::mem_wb_t  mem_wb;
    isa_pkg::flags_t    popped_flags;
    pipe_pkg::ex_mem_t  ex_mem;
    isa_pkg::flags_t    flags;
    logic               branch_taken;
    logic [`PC_W-1:0]   new_pc;

    row_t               rows [NUM_ROWS];
    pipe_pkg::id_ex_t   stim;
    pipe_pkg::mem_wb_t  wb_stim;
    isa_pkg::flags_t    pop_stim;
    pipe_pkg::ex_mem_t  shadow_ex_mem;
    isa_pkg::flags_t    shadow_flags;
    logic [31:0]        lfsr_state = 32'heb06_ec7c;
    int                 cycle_count = 0;

    execute_stage DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_ex        (id_ex),
        .mem_wb       (mem_wb),
        .popped_flags (popped_flags),
        .ex_mem       (ex_mem),
        .flags        (flags),
        .branch_taken (branch_taken),
        .new_pc       (new_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the table did not finish", cycle_count);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %0h expected %0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Younger match in EX/MEM first, then MEM/WB
    function automatic logic [1:0] fwd_source(input logic [`RADDR_W-1:0] idx);
        if (shadow_ex_mem.reg_write && shadow_ex_mem.rdest == idx) begin
            return SRC_EXM;
        end else if (mem_wb.reg_write && mem_wb.rdest == idx) begin
            return SRC_WB;
        end
        return SRC_REG;
    endfunction

    function automatic logic [`DATA_W-1:0] pick_operand(input logic [1:0] sel,
                                                        input logic [`DATA_W-1:0] reg_data);
        if (sel == SRC_EXM) begin
            return shadow_ex_mem.result;
        end else if (sel == SRC_WB) begin
            return mem_wb.data;
        end
        return reg_data;
    endfunction

    // Returns {carry, result}
    function automatic logic [`DATA_W:0] alu_model(
        input isa_pkg::alu_op_e     op,
        input logic [`DATA_W-1:0]   a,
        input logic [`DATA_W-1:0]   b,
        input logic [`SHAMT_W-1:0]  sh,
        input logic                 cin
    );
        logic [`DATA_W-1:0] r;
        logic               c;
        r = a; // NOP, SETC and CLRC leave op1 on the result
        c = cin;
        case (op)
            isa_pkg::ALU_MOV:  r = b;
            isa_pkg::ALU_ADD:  {c, r} = a + b;
            isa_pkg::ALU_SUB: begin
                r = a - b;
                c = (a < b); // Borrow
            end
            isa_pkg::ALU_AND:  r = a & b;
            isa_pkg::ALU_OR:   r = a | b;
            isa_pkg::ALU_NOT:  r = ~a;
            isa_pkg::ALU_INC: begin
                r = a + 1'b1;
                c = &a;
            end
            isa_pkg::ALU_DEC: begin
                r = a - 1'b1;
                c = (a == '0);
            end
            isa_pkg::ALU_SHL: begin
                r = a << sh;
                if (sh != 0) c = a[`DATA_W - int'(sh)];
            end
            isa_pkg::ALU_SHR: begin
                r = a >> sh;
                if (sh != 0) c = a[int'(sh) - 1];
            end
            isa_pkg::ALU_SETC: c = 1'b1;
            isa_pkg::ALU_CLRC: c = 1'b0;
            default: ;
        endcase
        return {c, r};
    endfunction

    task automatic build_stimulus(input row_t row);
        logic [31:0] rnd;
        stim        = '0;
        stim.alu_op = row.op;
        stim.jump   = row.jump;
        stim.rdest  = row.rdest;
        stim.rsrc   = row.rsrc;
        {stim.imm_sel, stim.flag_en, stim.flag_restore} = row.ctl;
        {stim.reg_write, stim.mem_read, stim.mem_write} = row.pass[5:3];
        {stim.mem_push, stim.mem_pop, stim.outport_en}  = row.pass[2:0];
        rnd = rand_bits(`DATA_W);
        stim.rdest_data = rnd[`DATA_W-1:0];
        rnd = rand_bits(`DATA_W);
        stim.rsrc_data = rnd[`DATA_W-1:0];
        rnd = rand_bits(`DATA_W);
        stim.imm = rnd[`DATA_W-1:0];
        rnd = rand_bits(`SHAMT_W);
        stim.shamt = rnd[`SHAMT_W-1:0];
        rnd = rand_bits(2);
        stim.wb_sel = rnd[1:0];
        stim.pc          = rand_bits(`PC_W);
        stim.pc_plus_one = stim.pc + 1'b1;
        {wb_stim.reg_write, wb_stim.rdest} = row.wb;
        rnd = rand_bits(`DATA_W);
        wb_stim.data = rnd[`DATA_W-1:0];
        rnd = rand_bits(3);
        pop_stim = rnd[2:0];
    endtask

    task automatic check_registered();
        check_value("ex_mem.result", ex_mem.result, shadow_ex_mem.result);
        check_value("ex_mem.store_data", ex_mem.store_data, shadow_ex_mem.store_data);
        check_value("ex_mem.rdest", ex_mem.rdest, shadow_ex_mem.rdest);
        check_value("ex_mem.reg_write", ex_mem.reg_write, shadow_ex_mem.reg_write);
        check_value("ex_mem.wb_sel", ex_mem.wb_sel, shadow_ex_mem.wb_sel);
        check_value("ex_mem.mem_read", ex_mem.mem_read, shadow_ex_mem.mem_read);
        check_value("ex_mem.mem_write", ex_mem.mem_write, shadow_ex_mem.mem_write);
        check_value("ex_mem.mem_push", ex_mem.mem_push, shadow_ex_mem.mem_push);
        check_value("ex_mem.mem_pop", ex_mem.mem_pop, shadow_ex_mem.mem_pop);
        check_value("ex_mem.outport_en", ex_mem.outport_en, shadow_ex_mem.outport_en);
        check_value("ex_mem.pc", ex_mem.pc, shadow_ex_mem.pc);
        check_value("ex_mem.pc_plus_one", ex_mem.pc_plus_one, shadow_ex_mem.pc_plus_one);
        check_value("flags", flags, shadow_flags);
    endtask

    task automatic check_and_step(input int idx);
        logic [1:0]               sel1;
        logic [1:0]               sel2;
        logic [`DATA_W-1:0]       op1;
        logic [`DATA_W-1:0]       op2;
        logic [`DATA_W:0]         alu_out;
        isa_pkg::flags_t          alu_flags;
        logic                     taken;
        logic signed [`PC_W-1:0]  target_ext;
        sel1 = fwd_source(id_ex.rdest);
        sel2 = fwd_source(id_ex.rsrc);
        assert ({sel1, sel2} == rows[idx].exp_src) else begin
            $display("Row %0d does not set up the forwarding case it was written for", idx);
            $display("Test FAILED");
            $fatal(1);
        end
        op1 = pick_operand(sel1, id_ex.rdest_data);
        op2 = id_ex.imm_sel ? id_ex.imm : pick_operand(sel2, id_ex.rsrc_data);
        alu_out     = alu_model(id_ex.alu_op, op1, op2, id_ex.shamt, shadow_flags.c);
        alu_flags.c = alu_out[`DATA_W];
        alu_flags.n = alu_out[`DATA_W-1];
        alu_flags.z = (alu_out[`DATA_W-1:0] == '0);
        case (id_ex.jump)
            isa_pkg::JMP_Z:      taken = shadow_flags.z;
            isa_pkg::JMP_N:      taken = shadow_flags.n;
            isa_pkg::JMP_C:      taken = shadow_flags.c;
            isa_pkg::JMP_ALWAYS: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
        target_ext = $signed(op1);

        check_registered(); // Holds the row before this one
        check_value("branch_taken", branch_taken, taken);
        check_value("new_pc", new_pc, taken ? target_ext : id_ex.pc);

        if (id_ex.flag_restore) begin
            shadow_flags = popped_flags;
        end else if (id_ex.flag_en) begin
            shadow_flags = alu_flags;
        end
        shadow_ex_mem.result      = alu_out[`DATA_W-1:0];
        shadow_ex_mem.store_data  = op2;
        shadow_ex_mem.rdest       = id_ex.rdest;
        shadow_ex_mem.reg_write   = id_ex.reg_write;
        shadow_ex_mem.wb_sel      = id_ex.wb_sel;
        shadow_ex_mem.mem_read    = id_ex.mem_read;
        shadow_ex_mem.mem_write   = id_ex.mem_write;
        shadow_ex_mem.mem_push    = id_ex.mem_push;
        shadow_ex_mem.mem_pop     = id_ex.mem_pop;
        shadow_ex_mem.outport_en  = id_ex.outport_en;
        shadow_ex_mem.pc          = id_ex.pc;
        shadow_ex_mem.pc_plus_one = id_ex.pc_plus_one;
    endtask

    // exp_src packs two 2-bit codes with 0 for reg, 1 for EX/MEM and 2 for WB
    initial begin
        rows[0]  = {isa_pkg::ALU_NOP, isa_pkg::JMP_NONE, 3'd1, 3'd2, 3'b000, 4'h0, 6'h00, 4'h0};
        rows[1]  = {isa_pkg::ALU_MOV, isa_pkg::JMP_NONE, 3'd1, 3'd2, 3'b010, 4'h0, 6'h20, 4'h0};
        rows[2]  = {isa_pkg::ALU_ADD, isa_pkg::JMP_NONE, 3'd3, 3'd1, 3'b010, 4'hB, 6'h20, 4'h9};
        rows[3]  = {isa_pkg::ALU_SUB, isa_pkg::JMP_NONE, 3'd3, 3'd3, 3'b010, 4'hB, 6'h20, 4'h5};
        rows[4]  = {isa_pkg::ALU_AND, isa_pkg::JMP_NONE, 3'd4, 3'd5, 3'b110, 4'hD, 6'h20, 4'h2};
        rows[5]  = {isa_pkg::ALU_OR, isa_pkg::JMP_NONE, 3'd5, 3'd4, 3'b010, 4'h0, 6'h20, 4'h1};
        rows[6]  = {isa_pkg::ALU_NOT, isa_pkg::JMP_NONE, 3'd6, 3'd0, 3'b010, 4'hE, 6'h00, 4'h8};
        rows[7]  = {isa_pkg::ALU_INC, isa_pkg::JMP_NONE, 3'd6, 3'd1, 3'b010, 4'h9, 6'h20, 4'h2};
        rows[8]  = {isa_pkg::ALU_DEC, isa_pkg::JMP_NONE, 3'd6, 3'd2, 3'b010, 4'h0, 6'h20, 4'h4};
        rows[9]  = {isa_pkg::ALU_SHL, isa_pkg::JMP_NONE, 3'd7, 3'd0, 3'b010, 4'h0, 6'h20, 4'h0};
        rows[10] = {isa_pkg::ALU_SHR, isa_pkg::JMP_NONE, 3'd7, 3'd7, 3'b010, 4'hF, 6'h20, 4'h5};
        rows[11] = {isa_pkg::ALU_SETC, isa_pkg::JMP_NONE, 3'd2, 3'd3, 3'b010, 4'h0, 6'h00, 4'h0};
        rows[12] = {isa_pkg::ALU_ADD, isa_pkg::JMP_NONE, 3'd2, 3'd3, 3'b100, 4'h0, 6'h20, 4'h0};
        rows[13] = {isa_pkg::ALU_CLRC, isa_pkg::JMP_NONE, 3'd0, 3'd1, 3'b011, 4'h0, 6'h00, 4'h0};
        rows[14] = {isa_pkg::ALU_SUB, isa_pkg::JMP_NONE, 3'd1, 3'd2, 3'b110, 4'h0, 6'h28, 4'h0};
        rows[15] = {isa_pkg::ALU_MOV, isa_pkg::JMP_Z, 3'd2, 3'd4, 3'b110, 4'h0, 6'h30, 4'h0};
        rows[16] = {isa_pkg::ALU_NOP, isa_pkg::JMP_N, 3'd2, 3'd0, 3'b000, 4'hA, 6'h04, 4'h4};
        rows[17] = {isa_pkg::ALU_NOP, isa_pkg::JMP_C, 3'd3, 3'd0, 3'b000, 4'hB, 6'h02, 4'h8};
        rows[18] = {isa_pkg::ALU_NOP, isa_pkg::JMP_ALWAYS, 3'd5, 3'd6, 3'b001, 4'h0, 6'h01, 4'h0};
        rows[19] = {isa_pkg::ALU_NOP, isa_pkg::JMP_NONE, 3'd4, 3'd4, 3'b000, 4'h0, 6'h00, 4'h0};
        rows[20] = {isa_pkg::ALU_INC, isa_pkg::JMP_NONE, 3'd0, 3'd0, 3'b010, 4'h0, 6'h20, 4'h0};
        rows[21] = {isa_pkg::ALU_ADD, isa_pkg::JMP_C, 3'd0, 3'd0, 3'b010, 4'h8, 6'h20, 4'h5};
        rows[22] = {isa_pkg::ALU_SHL, isa_pkg::JMP_Z, 3'd0, 3'd1, 3'b010, 4'h0, 6'h20, 4'h4};
        rows[23] = {isa_pkg::ALU_SHR, isa_pkg::JMP_N, 3'd3, 3'd0, 3'b110, 4'h8, 6'h00, 4'h1};
        rows[24] = {isa_pkg::ALU_DEC, isa_pkg::JMP_ALWAYS, 3'd5, 3'd5, 3'b010, 4'hD, 6'h20, 4'hA};
        rows[25] = {isa_pkg::ALU_AND, isa_pkg::JMP_NONE, 3'd1, 3'd2, 3'b010, 4'h0, 6'h20, 4'h0};
        rows[26] = {isa_pkg::ALU_OR, isa_pkg::JMP_NONE, 3'd1, 3'd1, 3'b110, 4'h0, 6'h20, 4'h5};
    end

    initial begin
        rst_n         = 1'b0;
        id_ex         = '0;
        mem_wb        = '0;
        popped_flags  = '0;
        shadow_ex_mem = '0;
        shadow_flags  = '0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_registered(); // Reset values

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            build_stimulus(rows[i]);
            id_ex        <= stim;
            mem_wb       <= wb_stim;
            popped_flags <= pop_stim;
            @(negedge clk);
            check_and_step(i);
        end

        @(negedge clk);
        check_registered();
        $display("Test OK");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/forwarding_unit.sv
rtl/alu.sv
rtl/flag_register.sv
rtl/branch_controller.sv
rtl/execute_stage.sv
verif/tb_execute_stage.sv
